//--- bench/standby_i2c_target_chk.sv
// Concurrent assertions on the top-level byte, response and RX handshakes and the error output
`default_nettype none

module standby_i2c_target_chk (
  input logic        clk_i,
  input logic        rst_ni,
  input logic        acq_valid_i,
  input logic        err_i,
  input logic        tx_byte_valid_i,
  input logic [7:0]  tx_byte_i,
  input logic        tx_byte_ready_i,
  input logic        host_resp_valid_i,
  input logic [31:0] host_resp_data_i,
  input logic        host_resp_ready_i,
  input logic        host_rx_valid_i,
  input logic [31:0] host_rx_data_i,
  input logic        host_rx_ready_i
);

  timeunit 1ns;
  timeprecision 100ps;

  logic seen_entry_q;

  // Set by the first acquisition entry after reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seen_entry_q <= 1'b0;
    end else if (acq_valid_i) begin
      seen_entry_q <= 1'b1;
    end
  end

  // Byte may only be dropped when the flow gives up on an error
  tx_byte_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tx_byte_valid_i && !tx_byte_ready_i |=>
      (tx_byte_valid_i && $stable(tx_byte_i)) || err_i)
    else $error("tx byte withdrawn or changed before acceptance");

  resp_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    host_resp_valid_i && !host_resp_ready_i |=>
      host_resp_valid_i && $stable(host_resp_data_i))
    else $error("response withdrawn or changed before acceptance");

  rx_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    host_rx_valid_i && !host_rx_ready_i |=>
      host_rx_valid_i && $stable(host_rx_data_i))
    else $error("RX word withdrawn or changed before acceptance");

  idle_err_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !seen_entry_q && !acq_valid_i |-> !err_i)
    else $error("error raised before any acquisition entry");

endmodule

`default_nettype wire

//--- bench/standby_i2c_target_tb.sv
// Testbench for the I2C standby target with directed write, read, error and back-pressure tests
`default_nettype none

module standby_i2c_target_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int ClkPeriod     = 20;
  localparam int NumTests      = 5;
  localparam int CyclesPerTest = 400;
  localparam int WaitLimit     = 50;
  localparam int Ww            = i2c_target_pkg::TtiWordWidth;

  // Selectors for the wait and ready helpers
  localparam int SelRx     = 0;
  localparam int SelResp   = 1;
  localparam int SelTxByte = 2;
  localparam int SelErr    = 3;
  localparam int SelCmdRdy = 4;
  localparam int SelTxRdy  = 5;

  logic                                     clk_i;
  logic                                     rst_ni;
  logic                                     acq_valid_i;
  logic [i2c_target_pkg::AcqEntryWidth-1:0] acq_entry_i;
  logic                                     tx_byte_valid_o;
  logic [7:0]                               tx_byte_o;
  logic                                     tx_byte_ready_i;
  logic                                     host_cmd_valid_i;
  logic [Ww-1:0]                            host_cmd_data_i;
  logic                                     host_cmd_ready_o;
  logic                                     host_tx_valid_i;
  logic [Ww-1:0]                            host_tx_data_i;
  logic                                     host_tx_ready_o;
  logic                                     host_resp_valid_o;
  logic [Ww-1:0]                            host_resp_data_o;
  logic                                     host_resp_ready_i;
  logic                                     host_rx_valid_o;
  logic [Ww-1:0]                            host_rx_data_o;
  logic                                     host_rx_ready_i;
  logic                                     err_o;

  integer     seed;
  int         checks;
  int         value_errs;
  int         timeout_errs;
  logic [7:0] sent_bytes [32];

  standby_i2c_target #(
    .QueueDepth (4)
  ) u_dut (.*);

  bind standby_i2c_target standby_i2c_target_chk u_chk (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .acq_valid_i       (acq_valid_i),
    .err_i             (err_o),
    .tx_byte_valid_i   (tx_byte_valid_o),
    .tx_byte_i         (tx_byte_o),
    .tx_byte_ready_i   (tx_byte_ready_i),
    .host_resp_valid_i (host_resp_valid_o),
    .host_resp_data_i  (host_resp_data_o),
    .host_resp_ready_i (host_resp_ready_i),
    .host_rx_valid_i   (host_rx_valid_o),
    .host_rx_data_i    (host_rx_data_o),
    .host_rx_ready_i   (host_rx_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  initial begin
    #(NumTests * CyclesPerTest * ClkPeriod);
    $display("ERROR: watchdog expired after %0d cycles, tests did not finish",
             NumTests * CyclesPerTest);
    $display("Simulation FAILED");
    $finish;
  end

  task automatic check_word(input string name, input logic [Ww-1:0] got,
                            input logic [Ww-1:0] exp);
    checks++;
    if (got !== exp) begin
      value_errs++;
      $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    checks++;
    if (got !== exp) begin
      value_errs++;
      $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_resp(input string name, input i2c_target_pkg::tti_resp_desc_t got,
                            input i2c_target_pkg::tti_resp_desc_t exp);
    checks++;
    if (got !== exp) begin
      value_errs++;
      $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_err(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      value_errs++;
      $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  function automatic logic level_of(input int sel);
    case (sel)
      SelRx:     level_of = host_rx_valid_o;
      SelResp:   level_of = host_resp_valid_o;
      SelTxByte: level_of = tx_byte_valid_o;
      SelErr:    level_of = err_o;
      SelCmdRdy: level_of = host_cmd_ready_o;
      default:   level_of = host_tx_ready_o;
    endcase
  endfunction

  function automatic logic [7:0] next_byte();
    logic [31:0] r;
    r = $random(seed);
    return r[7:0];
  endfunction

  // Little-endian packing with missing bytes read as zero
  function automatic logic [Ww-1:0] expected_word(input int w, input int n);
    logic [Ww-1:0] word;
    word = '0;
    for (int k = 0; k < 4; k++) begin
      if (4 * w + k < n) begin
        word[8*k +: 8] = sent_bytes[4*w + k];
      end
    end
    return word;
  endfunction

  task automatic align();
    @(posedge clk_i);
    #2;
  endtask

  // Returns at a falling edge with the signal high or after the limit
  task automatic wait_high(input int sel, input string what);
    int n;
    n = 0;
    @(negedge clk_i);
    while (!level_of(sel) && n < WaitLimit) begin
      @(negedge clk_i);
      n++;
    end
    if (!level_of(sel)) begin
      timeout_errs++;
      $display("ERROR: timed out waiting for %s", what);
    end
  endtask

  task automatic set_ready(input int sel, input logic v);
    case (sel)
      SelRx:   host_rx_ready_i = v;
      SelResp: host_resp_ready_i = v;
      default: tx_byte_ready_i = v;
    endcase
  endtask

  task automatic pulse_ready(input int sel);
    align();
    set_ready(sel, 1'b1);
    align();
    set_ready(sel, 1'b0);
  endtask

  task automatic push_host(input int sel, input logic [Ww-1:0] data);
    if (sel == SelCmdRdy) begin
      host_cmd_valid_i = 1'b1;
      host_cmd_data_i  = data;
    end else begin
      host_tx_valid_i = 1'b1;
      host_tx_data_i  = data;
    end
    wait_high(sel, (sel == SelCmdRdy) ? "host_cmd_ready_o" : "host_tx_ready_o");
    align();
    host_cmd_valid_i = 1'b0;
    host_tx_valid_i  = 1'b0;
  endtask

  // Holds one entry for one cycle from 2 ns after a rising edge
  task automatic send_entry(input i2c_target_pkg::acq_tag_e tag, input logic [7:0] data);
    i2c_target_pkg::acq_entry_t entry;
    entry.tag   = tag;
    entry.data  = data;
    acq_valid_i = 1'b1;
    acq_entry_i = entry;
    align();
    acq_valid_i = 1'b0;
  endtask

  task automatic fill_bytes(input int n);
    for (int i = 0; i < n; i++) begin
      sent_bytes[i] = next_byte();
    end
  endtask

  task automatic send_write_bytes(input int n);
    fill_bytes(n);
    for (int i = 0; i < n; i++) begin
      send_entry(i2c_target_pkg::AcqData, sent_bytes[i]);
    end
  endtask

  task automatic pop_rx_word(input logic [Ww-1:0] exp);
    wait_high(SelRx, "host_rx_valid_o");
    check_word("host_rx_data_o", host_rx_data_o, exp);
    pulse_ready(SelRx);
  endtask

  task automatic pop_resp(input int n);
    i2c_target_pkg::tti_resp_desc_t exp;
    exp.reserved    = '0;
    exp.data_length = 16'(n);
    wait_high(SelResp, "host_resp_valid_o");
    check_resp("host_resp_data_o", i2c_target_pkg::tti_resp_desc_t'(host_resp_data_o), exp);
    pulse_ready(SelResp);
  endtask

  task automatic expect_err(input logic v);
    @(negedge clk_i);
    check_err("err_o", err_o, v);
    align();
  endtask

  task automatic read_bytes(input int n);
    for (int i = 0; i < n; i++) begin
      wait_high(SelTxByte, "tx_byte_valid_o");
      check_byte("tx_byte_o", tx_byte_o, sent_bytes[i]);
      pulse_ready(SelTxByte);
    end
  endtask

  task automatic write_and_check(input int n);
    send_entry(i2c_target_pkg::AcqStartWr, 8'h00);
    send_write_bytes(n);
    expect_err(1'b0);
    send_entry(i2c_target_pkg::AcqStop, 8'h00);
    for (int w = 0; w < (n + 3) / 4; w++) begin
      pop_rx_word(expected_word(w, n));
    end
    pop_resp(n);
  endtask

  task automatic test_full_write();
    write_and_check(8);
  endtask

  task automatic test_partial_write();
    write_and_check(6);
  endtask

  task automatic test_read();
    i2c_target_pkg::tti_cmd_desc_t cmd;
    fill_bytes(8);
    cmd.reserved    = '0;
    cmd.data_length = 16'd5;
    push_host(SelCmdRdy, cmd);
    push_host(SelTxRdy, expected_word(0, 8));
    push_host(SelTxRdy, expected_word(1, 8));
    send_entry(i2c_target_pkg::AcqStartRd, 8'h00);
    read_bytes(5);
    expect_err(1'b0);
    send_entry(i2c_target_pkg::AcqStop, 8'h00);
    write_and_check(8);
  endtask

  task automatic test_read_error();
    i2c_target_pkg::tti_cmd_desc_t cmd;
    // Zero-length command
    cmd.reserved    = '0;
    cmd.data_length = 16'd0;
    push_host(SelCmdRdy, cmd);
    send_entry(i2c_target_pkg::AcqStartRd, 8'h00);
    wait_high(SelErr, "err_o");
    check_err("err_o", err_o, 1'b1);
    align();
    send_entry(i2c_target_pkg::AcqStop, 8'h00);
    expect_err(1'b0);
    // NACK after two of four bytes
    fill_bytes(4);
    cmd.data_length = 16'd4;
    push_host(SelCmdRdy, cmd);
    push_host(SelTxRdy, expected_word(0, 4));
    send_entry(i2c_target_pkg::AcqStartRd, 8'h00);
    read_bytes(2);
    wait_high(SelTxByte, "tx_byte_valid_o");
    align();
    send_entry(i2c_target_pkg::AcqNack, 8'h00);
    wait_high(SelErr, "err_o");
    check_err("err_o", err_o, 1'b1);
    align();
    send_entry(i2c_target_pkg::AcqStop, 8'h00);
    expect_err(1'b0);
  endtask

  task automatic test_back_pressure();
    // Four words fill the RX queue and the fifth waits in the flow
    send_entry(i2c_target_pkg::AcqStartWr, 8'h00);
    send_write_bytes(20);
    expect_err(1'b0);
    send_entry(i2c_target_pkg::AcqData, next_byte());
    wait_high(SelErr, "err_o");
    check_err("err_o", err_o, 1'b1);
    align();
    for (int w = 0; w < 4; w++) begin
      pop_rx_word(expected_word(w, 20));
    end
    send_entry(i2c_target_pkg::AcqStop, 8'h00);
    expect_err(1'b0);
    write_and_check(8);
  endtask

  initial begin
    seed              = 32'hc573_792e;
    checks            = 0;
    value_errs        = 0;
    timeout_errs      = 0;
    rst_ni            = 1'b0;
    acq_valid_i       = 1'b0;
    acq_entry_i       = '0;
    tx_byte_ready_i   = 1'b0;
    host_cmd_valid_i  = 1'b0;
    host_cmd_data_i   = '0;
    host_tx_valid_i   = 1'b0;
    host_tx_data_i    = '0;
    host_resp_ready_i = 1'b0;
    host_rx_ready_i   = 1'b0;
    repeat (2) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    align();

    test_full_write();
    test_partial_write();
    test_read();
    test_read_error();
    test_back_pressure();

    $display("Checks: %0d, value errors: %0d, timeouts: %0d",
             checks, value_errs, timeout_errs);
    if (value_errs == 0 && timeout_errs == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- hw/flow_standby_i2c.sv
// I2C standby flow FSM translating acquisition entries to and from the TTI queues
`default_nettype none

module flow_standby_i2c (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       acq_valid_i,
  input  i2c_target_pkg::acq_entry_t acq_entry_i,
  tti_if.flow                        tti_o,
  output logic                       tx_byte_valid_o,
  output logic [7:0]                 tx_byte_o,
  input  logic                       tx_byte_ready_i,
  output logic                       err_o
);

  typedef enum logic [3:0] {
    AwaitStart   = 4'd0,
    ReceiveByte  = 4'd1,
    PushWord     = 4'd2,
    PushResponse = 4'd3,
    PopCommand   = 4'd4,
    PopWord      = 4'd5,
    SendByte     = 4'd6,
    AwaitStop    = 4'd7,
    ReportError  = 4'd8
  } state_e;

  state_e                                  state_q, state_d;
  logic [i2c_target_pkg::TtiWordWidth-1:0] word_q, word_d;
  logic [15:0]                             cnt_q, cnt_d;
  logic [15:0]                             read_len_q;
  logic                                    stop_pend_q, stop_pend_d;
  logic [1:0]                              byte_sel;

  // Decoded entry
  logic is_data, is_start_wr, is_start_rd, is_stop, is_nack;

  // Datapath controls from the FSM
  logic cnt_clr, cnt_inc;
  logic buf_clr, buf_wr, buf_load;
  logic len_load, stop_set;

  assign is_data     = acq_valid_i && (acq_entry_i.tag == i2c_target_pkg::AcqData);
  assign is_start_wr = acq_valid_i && (acq_entry_i.tag == i2c_target_pkg::AcqStartWr);
  assign is_start_rd = acq_valid_i && (acq_entry_i.tag == i2c_target_pkg::AcqStartRd);
  assign is_stop     = acq_valid_i && (acq_entry_i.tag == i2c_target_pkg::AcqStop);
  assign is_nack     = acq_valid_i && (acq_entry_i.tag == i2c_target_pkg::AcqNack);

  // Low counter bits pick the byte within the word
  assign byte_sel  = cnt_q[1:0];
  assign tx_byte_o = word_q[{byte_sel, 3'b000} +: 8];

  assign tti_o.rx_data               = word_q;
  assign tti_o.resp_data.reserved    = '0;
  assign tti_o.resp_data.data_length = cnt_q;

  always_comb begin
    word_d = word_q;
    if (buf_clr) begin
      word_d = '0;
    end
    if (buf_wr) begin
      word_d[{byte_sel, 3'b000} +: 8] = acq_entry_i.data;
    end
    if (buf_load) begin
      word_d = tti_o.tx_data;
    end
  end

  assign cnt_d       = cnt_clr ? '0 : (cnt_inc ? cnt_q + 16'd1 : cnt_q);
  assign stop_pend_d = cnt_clr ? 1'b0 : (stop_set ? 1'b1 : stop_pend_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= AwaitStart;
      cnt_q       <= '0;
      stop_pend_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      cnt_q       <= cnt_d;
      stop_pend_q <= stop_pend_d;
    end
  end

  always_ff @(posedge clk_i) begin
    word_q <= word_d;
    if (len_load) begin
      read_len_q <= tti_o.cmd_data.data_length;
    end
  end

  always_comb begin
    state_d         = state_q;
    cnt_clr         = 1'b0;
    cnt_inc         = 1'b0;
    buf_clr         = 1'b0;
    buf_wr          = 1'b0;
    buf_load        = 1'b0;
    len_load        = 1'b0;
    stop_set        = 1'b0;
    tti_o.cmd_ready  = 1'b0;
    tti_o.tx_ready   = 1'b0;
    tti_o.rx_valid   = 1'b0;
    tti_o.resp_valid = 1'b0;
    tx_byte_valid_o = 1'b0;
    err_o           = 1'b0;

    unique case (state_q)
      AwaitStart: begin
        if (is_start_wr) begin
          state_d = ReceiveByte;
          cnt_clr = 1'b1;
          buf_clr = 1'b1;
        end else if (is_start_rd) begin
          state_d = PopCommand;
          cnt_clr = 1'b1;
        end else if (is_data) begin
          state_d = ReportError;
        end
      end
      ReceiveByte: begin
        if (is_data) begin
          buf_wr  = 1'b1;
          cnt_inc = 1'b1;
          if (byte_sel == 2'd3) begin
            state_d = PushWord;
          end
        end else if (is_stop) begin
          // Partial word goes out before the response
          if (byte_sel != 2'd0) begin
            state_d  = PushWord;
            stop_set = 1'b1;
          end else begin
            state_d = PushResponse;
          end
        end else if (acq_valid_i) begin
          state_d = ReportError;
        end
      end
      PushWord: begin
        tti_o.rx_valid = 1'b1;
        if (tti_o.rx_ready) begin
          buf_clr = 1'b1;
          state_d = (stop_pend_q || is_stop) ? PushResponse : ReceiveByte;
          // A byte arriving with the push lands in the freshly cleared slot 0
          if (is_data && !stop_pend_q) begin
            buf_wr  = 1'b1;
            cnt_inc = 1'b1;
          end else if (acq_valid_i && !is_stop) begin
            state_d = ReportError;
          end
        end else if (is_stop) begin
          stop_set = 1'b1;
        end else if (acq_valid_i) begin
          state_d = ReportError;
        end
      end
      PushResponse: begin
        tti_o.resp_valid = 1'b1;
        if (tti_o.resp_ready) begin
          state_d = AwaitStart;
          if (is_start_wr) begin
            state_d = ReceiveByte;
            cnt_clr = 1'b1;
            buf_clr = 1'b1;
          end else if (is_start_rd) begin
            state_d = PopCommand;
            cnt_clr = 1'b1;
          end else if (is_data || is_nack) begin
            state_d = ReportError;
          end
        end else if (acq_valid_i && !is_stop) begin
          state_d = ReportError;
        end
      end
      PopCommand: begin
        tti_o.cmd_ready = 1'b1;
        if (tti_o.cmd_valid) begin
          len_load = 1'b1;
          state_d  = (tti_o.cmd_data.data_length == 16'd0) ? ReportError : PopWord;
        end
        if (acq_valid_i) begin
          state_d = ReportError;
        end
      end
      PopWord: begin
        tti_o.tx_ready = 1'b1;
        if (tti_o.tx_valid) begin
          buf_load = 1'b1;
          state_d  = SendByte;
        end
        if (acq_valid_i) begin
          state_d = ReportError;
        end
      end
      SendByte: begin
        tx_byte_valid_o = 1'b1;
        if (tx_byte_ready_i) begin
          cnt_inc = 1'b1;
          if (cnt_q + 16'd1 == read_len_q) begin
            state_d = AwaitStop;
          end else if (byte_sel == 2'd3) begin
            state_d = PopWord;
          end
        end
        // NACK or any other entry before the count is reached
        if (acq_valid_i) begin
          state_d = ReportError;
        end
      end
      AwaitStop: begin
        // Master NACK on the last byte is normal
        if (is_stop) begin
          state_d = AwaitStart;
        end else if (acq_valid_i && !is_nack) begin
          state_d = ReportError;
        end
      end
      ReportError: begin
        err_o = 1'b1;
        if (is_stop) begin
          state_d = AwaitStart;
        end
      end
      default: begin
        state_d = ReportError;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- hw/i2c_target_pkg.sv
// Acquisition entry tags and layout, TTI word width, command and response descriptors
`default_nettype none

package i2c_target_pkg;

  // Acquisition entry from the byte-level I2C target engine
  localparam int AcqTagWidth = 3;
  localparam int AcqEntryWidth = AcqTagWidth + 8;

  typedef enum logic [AcqTagWidth-1:0] {
    AcqData    = 3'd0,
    AcqStartWr = 3'd1,
    AcqStartRd = 3'd2,
    AcqStop    = 3'd3,
    AcqNack    = 3'd4
  } acq_tag_e;

  // Tag in the upper bits, byte in the lower eight
  typedef struct packed {
    acq_tag_e   tag;
    logic [7:0] data;
  } acq_entry_t;

  // RX and TX queue words
  localparam int TtiWordWidth = 32;

  // Command descriptor, length in the low half of the word
  typedef struct packed {
    logic [15:0] reserved;
    logic [15:0] data_length;
  } tti_cmd_desc_t;

  // Response descriptor, upper half always zero
  typedef struct packed {
    logic [15:0] reserved;
    logic [15:0] data_length;
  } tti_resp_desc_t;

  localparam int QueueDepthDefault = 4;

endpackage

`default_nettype wire

//--- hw/standby_i2c_target.sv
// Top level of the I2C standby target, standby flow plus TTI queues on plain ports
`default_nettype none

module standby_i2c_target #(
  parameter int QueueDepth = i2c_target_pkg::QueueDepthDefault
) (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  logic                                     acq_valid_i,
  input  logic [i2c_target_pkg::AcqEntryWidth-1:0] acq_entry_i,
  output logic                                     tx_byte_valid_o,
  output logic [7:0]                               tx_byte_o,
  input  logic                                     tx_byte_ready_i,
  input  logic                                     host_cmd_valid_i,
  input  logic [i2c_target_pkg::TtiWordWidth-1:0]  host_cmd_data_i,
  output logic                                     host_cmd_ready_o,
  input  logic                                     host_tx_valid_i,
  input  logic [i2c_target_pkg::TtiWordWidth-1:0]  host_tx_data_i,
  output logic                                     host_tx_ready_o,
  output logic                                     host_resp_valid_o,
  output logic [i2c_target_pkg::TtiWordWidth-1:0]  host_resp_data_o,
  input  logic                                     host_resp_ready_i,
  output logic                                     host_rx_valid_o,
  output logic [i2c_target_pkg::TtiWordWidth-1:0]  host_rx_data_o,
  input  logic                                     host_rx_ready_i,
  output logic                                     err_o
);

  tti_if tti_bus ();

  flow_standby_i2c u_flow (
    .clk_i,
    .rst_ni,
    .acq_valid_i,
    .acq_entry_i     (i2c_target_pkg::acq_entry_t'(acq_entry_i)),
    .tti_o           (tti_bus.flow),
    .tx_byte_valid_o,
    .tx_byte_o,
    .tx_byte_ready_i,
    .err_o
  );

  tti_queues #(
    .QueueDepth (QueueDepth)
  ) u_queues (
    .clk_i,
    .rst_ni,
    .flow_o            (tti_bus.queues),
    .host_cmd_valid_i,
    .host_cmd_data_i,
    .host_cmd_ready_o,
    .host_tx_valid_i,
    .host_tx_data_i,
    .host_tx_ready_o,
    .host_resp_valid_o,
    .host_resp_data_o,
    .host_resp_ready_i,
    .host_rx_valid_o,
    .host_rx_data_o,
    .host_rx_ready_i
  );

endmodule

`default_nettype wire

//--- hw/tti_fifo.sv
// Synchronous valid/ready FIFO with circular buffer and occupancy count
`default_nettype none

module tti_fifo #(
  parameter int Width = 32,
  parameter int Depth = 4
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             wvalid_i,
  output logic             wready_o,
  input  logic [Width-1:0] wdata_i,
  output logic             rvalid_o,
  input  logic             rready_i,
  output logic [Width-1:0] rdata_o
);

  localparam int PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntWidth = $clog2(Depth + 1);
  localparam logic [PtrWidth-1:0] LastPtr = PtrWidth'(Depth - 1);
  localparam logic [CntWidth-1:0] FullCnt = CntWidth'(Depth);

  logic [Width-1:0]    mem_q [Depth];
  logic [PtrWidth-1:0] wptr_q;
  logic [PtrWidth-1:0] rptr_q;
  logic [CntWidth-1:0] cnt_q;
  logic                push;
  logic                pop;

  assign wready_o = (cnt_q != FullCnt);
  assign rvalid_o = (cnt_q != '0);
  assign rdata_o  = mem_q[rptr_q];

  assign push = wvalid_i && wready_o;
  assign pop  = rvalid_o && rready_i;

  // Storage, written only on an accepted push
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wptr_q] <= wdata_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q <= '0;
      rptr_q <= '0;
      cnt_q  <= '0;
    end else begin
      if (push) begin
        wptr_q <= (wptr_q == LastPtr) ? '0 : wptr_q + 1'b1;
      end
      if (pop) begin
        rptr_q <= (rptr_q == LastPtr) ? '0 : rptr_q + 1'b1;
      end
      // Simultaneous push and pop leaves the count unchanged
      if (push && !pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (pop && !push) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/tti_if.sv
// TTI channel bundle between the standby flow and its queues, with flow and queues modports
`default_nettype none

interface tti_if;

  // Command descriptors, queue to flow
  logic                                      cmd_valid;
  logic                                      cmd_ready;
  i2c_target_pkg::tti_cmd_desc_t             cmd_data;

  // TX data words, queue to flow
  logic                                      tx_valid;
  logic                                      tx_ready;
  logic [i2c_target_pkg::TtiWordWidth-1:0]   tx_data;

  // Response descriptors, flow to queue
  logic                                      resp_valid;
  logic                                      resp_ready;
  i2c_target_pkg::tti_resp_desc_t            resp_data;

  // RX data words, flow to queue
  logic                                      rx_valid;
  logic                                      rx_ready;
  logic [i2c_target_pkg::TtiWordWidth-1:0]   rx_data;

  modport flow (
    input  cmd_valid, cmd_data, tx_valid, tx_data, resp_ready, rx_ready,
    output cmd_ready, tx_ready, resp_valid, resp_data, rx_valid, rx_data
  );

  modport queues (
    output cmd_valid, cmd_data, tx_valid, tx_data, resp_ready, rx_ready,
    input  cmd_ready, tx_ready, resp_valid, resp_data, rx_valid, rx_data
  );

endinterface

`default_nettype wire

//--- hw/tti_queues.sv
// Command, TX, response and RX queues between the host and the standby flow
`default_nettype none

module tti_queues #(
  parameter int QueueDepth = 4
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  tti_if.queues                                   flow_o,
  input  logic                                    host_cmd_valid_i,
  input  logic [i2c_target_pkg::TtiWordWidth-1:0] host_cmd_data_i,
  output logic                                    host_cmd_ready_o,
  input  logic                                    host_tx_valid_i,
  input  logic [i2c_target_pkg::TtiWordWidth-1:0] host_tx_data_i,
  output logic                                    host_tx_ready_o,
  output logic                                    host_resp_valid_o,
  output logic [i2c_target_pkg::TtiWordWidth-1:0] host_resp_data_o,
  input  logic                                    host_resp_ready_i,
  output logic                                    host_rx_valid_o,
  output logic [i2c_target_pkg::TtiWordWidth-1:0] host_rx_data_o,
  input  logic                                    host_rx_ready_i
);

  logic [i2c_target_pkg::TtiWordWidth-1:0] cmd_rdata;
  logic [i2c_target_pkg::TtiWordWidth-1:0] resp_wdata;

  // Descriptor words take their package types at this boundary
  assign flow_o.cmd_data = i2c_target_pkg::tti_cmd_desc_t'(cmd_rdata);
  assign resp_wdata      = flow_o.resp_data;

  // Host to flow
  tti_fifo #(
    .Width (i2c_target_pkg::TtiWordWidth),
    .Depth (QueueDepth)
  ) u_cmd_q (
    .clk_i,
    .rst_ni,
    .wvalid_i (host_cmd_valid_i),
    .wready_o (host_cmd_ready_o),
    .wdata_i  (host_cmd_data_i),
    .rvalid_o (flow_o.cmd_valid),
    .rready_i (flow_o.cmd_ready),
    .rdata_o  (cmd_rdata)
  );

  tti_fifo #(
    .Width (i2c_target_pkg::TtiWordWidth),
    .Depth (QueueDepth)
  ) u_tx_q (
    .clk_i,
    .rst_ni,
    .wvalid_i (host_tx_valid_i),
    .wready_o (host_tx_ready_o),
    .wdata_i  (host_tx_data_i),
    .rvalid_o (flow_o.tx_valid),
    .rready_i (flow_o.tx_ready),
    .rdata_o  (flow_o.tx_data)
  );

  // Flow to host
  tti_fifo #(
    .Width (i2c_target_pkg::TtiWordWidth),
    .Depth (QueueDepth)
  ) u_resp_q (
    .clk_i,
    .rst_ni,
    .wvalid_i (flow_o.resp_valid),
    .wready_o (flow_o.resp_ready),
    .wdata_i  (resp_wdata),
    .rvalid_o (host_resp_valid_o),
    .rready_i (host_resp_ready_i),
    .rdata_o  (host_resp_data_o)
  );

  tti_fifo #(
    .Width (i2c_target_pkg::TtiWordWidth),
    .Depth (QueueDepth)
  ) u_rx_q (
    .clk_i,
    .rst_ni,
    .wvalid_i (flow_o.rx_valid),
    .wready_o (flow_o.rx_ready),
    .wdata_i  (flow_o.rx_data),
    .rvalid_o (host_rx_valid_o),
    .rready_i (host_rx_ready_i),
    .rdata_o  (host_rx_data_o)
  );

endmodule

`default_nettype wire

//--- standby_i2c.f
hw/i2c_target_pkg.sv
hw/tti_if.sv
hw/tti_fifo.sv
hw/tti_queues.sv
hw/flow_standby_i2c.sv
hw/standby_i2c_target.sv
bench/standby_i2c_target_chk.sv
bench/standby_i2c_target_tb.sv
